//--- cu_pkg.sv
package cu_pkg;

    // graduation list index width
    parameter int GL_INDEX_W = 5;

    // checkpoint id width
    parameter int CHKP_W = 2;

    // instructions retired per cycle
    parameter int RETIRE_W = 2;

    // source of the next pc in fetch
    typedef enum logic [1:0] {
        NEXT_PC_BP_OR_PC4 = 2'd0,
        NEXT_PC_JUMP      = 2'd1,
        NEXT_PC_KEEP      = 2'd2
    } next_pc_sel_e;

    // which stage provides the jump target
    typedef enum logic [1:0] {
        FETCH_SEL_DECODE    = 2'd0,
        FETCH_SEL_EXECUTION = 2'd1,
        FETCH_SEL_CSR       = 2'd2,
        FETCH_SEL_CSR_RW    = 2'd3
    } fetch_sel_e;

endpackage

//--- cu_event_if.sv
interface cu_event_if;

    // registered redirects, high for one cycle
    logic exc_redirect;
    logic csr_redirect;
    // exception register input, used to mask commit
    logic exc_next;

    logic wb_mispredict;
    logic decode_mispredict;
    logic jal_redirect;

    // csr fence somewhere between decode and commit
    logic fence_hold;
    logic csr_fence_any;
    logic commit_csr_fence;

    modport src (
        output exc_redirect, csr_redirect, exc_next,
        output wb_mispredict, decode_mispredict, jal_redirect,
        output fence_hold, csr_fence_any, commit_csr_fence
    );

    modport dst (
        input exc_redirect, csr_redirect, exc_next,
        input wb_mispredict, decode_mispredict, jal_redirect,
        input fence_hold, csr_fence_any, commit_csr_fence
    );

endinterface

//--- cu_event_state.sv
module cu_event_state #(
    parameter int RETIRE_W = cu_pkg::RETIRE_W
) (
    input  logic                clk_i,
    input  logic                rstn_i,

    input  logic                id_valid_i,
    input  logic                id_is_branch_i,
    input  logic                id_predicted_branch_i,
    input  logic                id_valid_jal_i,
    input  logic                id_csr_fence_i,

    input  logic                wb_valid_i,
    input  logic                branch_pred_ok_i,

    input  logic                commit_valid_i,
    input  logic                commit_xcpt_i,
    input  logic                commit_ecall_i,
    input  logic                commit_csr_fence_i,
    input  logic                commit_fence_i,
    input  logic                commit_fencei_i,
    input  logic [RETIRE_W-1:0] commit_retire_i,
    input  logic [RETIRE_W-1:0] commit_regfile_we_i,
    input  logic                commit_stall_i,

    input  logic                csr_eret_i,
    input  logic                csr_exception_i,

    cu_event_if.src             events,

    output logic                invalidate_icache_o,
    output logic                invalidate_buffer_o,
    output logic                commit_flush_o,
    output logic [RETIRE_W-1:0] commit_update_o,
    output logic                enable_commit_o
);

    logic exc_cause;
    logic exc_q;
    logic exc_d;
    logic csr_q;
    logic csr_d;
    logic fence_pending_q;

    // any cause that sends fetch to the trap or return vector
    assign exc_cause = (commit_valid_i && (commit_xcpt_i || commit_ecall_i)) ||
                       csr_eret_i || csr_exception_i;

    // a redirect cannot fire twice in a row
    assign exc_d = exc_q ? 1'b0 : exc_cause;
    assign csr_d = csr_q ? 1'b0 : (commit_valid_i && commit_csr_fence_i && !exc_cause);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            exc_q <= 1'b0;
            csr_q <= 1'b0;
        end else begin
            exc_q <= exc_d;
            csr_q <= csr_d;
        end
    end

    // csr fence seen at decode and not yet committed
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            fence_pending_q <= 1'b0;
        end else if (exc_q || events.wb_mispredict) begin
            fence_pending_q <= 1'b0;
        end else if (id_valid_i && id_csr_fence_i) begin
            fence_pending_q <= 1'b1;
        end else if (commit_valid_i && commit_csr_fence_i) begin
            fence_pending_q <= 1'b0;
        end
    end

    assign events.exc_redirect      = exc_q;
    assign events.csr_redirect      = csr_q;
    assign events.exc_next          = exc_d;
    assign events.wb_mispredict     = wb_valid_i && !branch_pred_ok_i;
    assign events.decode_mispredict = id_valid_i && !id_is_branch_i && id_predicted_branch_i;
    assign events.jal_redirect      = id_valid_jal_i;
    assign events.fence_hold        = (id_valid_i && id_csr_fence_i) || fence_pending_q ||
                                      (commit_valid_i && commit_fence_i);
    assign events.csr_fence_any     = id_csr_fence_i || fence_pending_q || commit_csr_fence_i;
    assign events.commit_csr_fence  = commit_valid_i && commit_csr_fence_i;

    // fence.i may follow self-modifying code
    assign invalidate_icache_o = commit_valid_i && commit_fencei_i;
    assign invalidate_buffer_o = commit_valid_i &&
                                 (commit_fencei_i || exc_q ||
                                  (commit_csr_fence_i && !commit_fence_i));

    // no free list or rename update while an exception is being taken
    assign commit_update_o = commit_retire_i & commit_regfile_we_i & {RETIRE_W{~exc_d}};
    assign enable_commit_o = !commit_stall_i && !exc_d;
    assign commit_flush_o  = exc_q;

endmodule

//--- cu_frontend_ctrl.sv
module cu_frontend_ctrl (
    cu_event_if.dst              events,

    input  logic                 miss_icache_i,
    input  logic                 ready_icache_i,
    input  logic                 csr_stall_i,
    input  logic                 ir_full_iq_i,

    output cu_pkg::next_pc_sel_e next_pc_sel_o,
    output cu_pkg::fetch_sel_e   fetch_sel_o,
    output logic                 flush_if_o,
    output logic                 flush_id_o,
    output logic                 stall_if_1_o,
    output logic                 stall_if_2_o,
    output logic                 stall_id_o
);

    import cu_pkg::*;

    logic redirect;
    logic soft_flush;

    // redirects that discard everything fetched so far
    assign redirect = events.exc_redirect || events.csr_redirect || events.wb_mispredict;

    // fetch-only flushes, suppressed while the csr file stalls
    assign soft_flush = !csr_stall_i &&
                        (events.csr_fence_any || events.fence_hold ||
                         events.jal_redirect || events.decode_mispredict);

    assign flush_if_o = redirect || soft_flush;
    assign flush_id_o = redirect;

    always_comb begin
        stall_if_1_o = 1'b0;
        stall_if_2_o = 1'b0;
        stall_id_o   = 1'b0;
        if (csr_stall_i || ir_full_iq_i) begin
            stall_if_1_o = 1'b1;
            stall_if_2_o = 1'b1;
            stall_id_o   = 1'b1;
        end else if (miss_icache_i) begin
            stall_if_1_o = 1'b1;
            stall_if_2_o = 1'b1;
        end else if (events.commit_csr_fence || !ready_icache_i) begin
            // miss already excluded above
            stall_if_1_o = 1'b1;
        end
    end

    always_comb begin
        if (redirect || events.decode_mispredict || events.jal_redirect) begin
            next_pc_sel_o = NEXT_PC_JUMP;
        end else if (stall_if_1_o || events.fence_hold) begin
            next_pc_sel_o = NEXT_PC_KEEP;
        end else begin
            next_pc_sel_o = NEXT_PC_BP_OR_PC4;
        end
    end

    // exceptions win over csr fences, which win over branches
    always_comb begin
        if (events.exc_redirect) begin
            fetch_sel_o = FETCH_SEL_CSR;
        end else if (events.csr_redirect) begin
            fetch_sel_o = FETCH_SEL_CSR_RW;
        end else if (events.wb_mispredict) begin
            fetch_sel_o = FETCH_SEL_EXECUTION;
        end else begin
            fetch_sel_o = FETCH_SEL_DECODE;
        end
    end

endmodule

//--- cu_backend_ctrl.sv
module cu_backend_ctrl #(
    parameter int GL_INDEX_W = cu_pkg::GL_INDEX_W
) (
    cu_event_if.dst                 events,

    input  logic                    csr_stall_i,
    input  logic                    exe_stall_i,
    input  logic                    rr_gl_full_i,
    input  logic                    ir_empty_free_list_i,
    input  logic                    ir_out_of_chkp_i,
    input  logic                    ir_valid_i,
    input  logic                    ir_is_branch_i,

    input  logic                    wb_valid_i,
    input  logic                    wb_write_enable_i,
    input  logic                    wb_checkpoint_done_i,
    input  logic                    branch_pred_ok_i,
    input  logic [GL_INDEX_W-1:0]   wb_gl_index_i,

    input  logic                    commit_valid_i,
    input  logic                    commit_xcpt_i,
    input  logic                    csr_exception_i,
    input  logic                    commit_write_enable_i,

    output logic                    flush_ir_o,
    output logic                    flush_rr_o,
    output logic                    flush_exe_o,
    output logic                    kill_exe_o,
    output logic                    stall_iq_o,
    output logic                    stall_ir_o,
    output logic                    stall_rr_o,
    output logic                    stall_exe_o,
    output logic                    do_checkpoint_o,
    output logic                    do_recover_o,
    output logic                    delete_checkpoint_o,
    output logic                    flush_gl_o,
    output logic [GL_INDEX_W-1:0]   flush_gl_index_o,
    output logic                    rf_write_enable_o
);

    always_comb begin
        flush_ir_o  = 1'b0;
        flush_rr_o  = 1'b0;
        flush_exe_o = 1'b0;
        kill_exe_o  = 1'b0;
        if (events.exc_redirect) begin
            flush_ir_o  = 1'b1;
            flush_rr_o  = 1'b1;
            flush_exe_o = 1'b1;
        end else if (events.wb_mispredict) begin
            // the branch itself is in exe, so kill rather than flush
            flush_ir_o = 1'b1;
            flush_rr_o = 1'b1;
            kill_exe_o = 1'b1;
        end else if (!exe_stall_i && rr_gl_full_i) begin
            flush_rr_o = 1'b1;
        end
    end

    always_comb begin
        stall_iq_o  = 1'b0;
        stall_ir_o  = 1'b0;
        stall_rr_o  = 1'b0;
        stall_exe_o = 1'b0;
        if (csr_stall_i) begin
            stall_iq_o  = 1'b1;
            stall_ir_o  = 1'b1;
            stall_rr_o  = 1'b1;
            stall_exe_o = 1'b1;
        end else if (exe_stall_i || rr_gl_full_i) begin
            stall_iq_o = 1'b1;
            stall_ir_o = 1'b1;
            stall_rr_o = 1'b1;
        end else if (ir_empty_free_list_i || ir_out_of_chkp_i) begin
            stall_iq_o = 1'b1;
        end
    end

    // rename snapshot for every branch that actually leaves rename
    assign do_checkpoint_o = ir_valid_i && ir_is_branch_i && !ir_out_of_chkp_i &&
                             !flush_ir_o && !stall_ir_o;

    assign do_recover_o        = events.wb_mispredict && wb_checkpoint_done_i;
    assign delete_checkpoint_o = wb_valid_i && branch_pred_ok_i && wb_checkpoint_done_i;

    // younger entries after the mispredicted branch are dropped
    assign flush_gl_o       = events.wb_mispredict;
    assign flush_gl_index_o = events.wb_mispredict ? wb_gl_index_i : '0;

    assign rf_write_enable_o = (commit_valid_i && commit_write_enable_i &&
                                !commit_xcpt_i && !csr_exception_i) ||
                               (wb_valid_i && wb_write_enable_i);

endmodule

//--- control_unit.sv
module control_unit #(
    parameter int GL_INDEX_W = cu_pkg::GL_INDEX_W,
    parameter int RETIRE_W   = cu_pkg::RETIRE_W
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,

    input  logic                  miss_icache_i,
    input  logic                  ready_icache_i,
    input  logic                  id_valid_i,
    input  logic                  id_is_branch_i,
    input  logic                  id_predicted_branch_i,
    input  logic                  id_valid_jal_i,
    input  logic                  id_csr_fence_i,

    input  logic                  ir_valid_i,
    input  logic                  ir_is_branch_i,
    input  logic                  ir_out_of_chkp_i,
    input  logic                  ir_full_iq_i,
    input  logic                  ir_empty_free_list_i,

    input  logic                  rr_gl_full_i,
    input  logic                  exe_stall_i,

    input  logic                  wb_valid_i,
    input  logic                  wb_write_enable_i,
    input  logic                  wb_checkpoint_done_i,
    input  logic [GL_INDEX_W-1:0] wb_gl_index_i,
    input  logic                  branch_pred_ok_i,

    input  logic                  commit_valid_i,
    input  logic                  commit_xcpt_i,
    input  logic                  commit_ecall_i,
    input  logic                  commit_csr_fence_i,
    input  logic                  commit_fence_i,
    input  logic                  commit_fencei_i,
    input  logic                  commit_write_enable_i,
    input  logic [RETIRE_W-1:0]   commit_retire_i,
    input  logic [RETIRE_W-1:0]   commit_regfile_we_i,
    input  logic                  commit_stall_i,

    input  logic                  csr_eret_i,
    input  logic                  csr_exception_i,
    input  logic                  csr_stall_i,

    output cu_pkg::next_pc_sel_e  next_pc_sel_o,
    output cu_pkg::fetch_sel_e    fetch_sel_o,

    output logic                  flush_if_o,
    output logic                  flush_id_o,
    output logic                  flush_ir_o,
    output logic                  flush_rr_o,
    output logic                  flush_exe_o,
    output logic                  kill_exe_o,

    output logic                  stall_if_1_o,
    output logic                  stall_if_2_o,
    output logic                  stall_id_o,
    output logic                  stall_iq_o,
    output logic                  stall_ir_o,
    output logic                  stall_rr_o,
    output logic                  stall_exe_o,

    output logic                  invalidate_icache_o,
    output logic                  invalidate_buffer_o,
    output logic                  rf_write_enable_o,

    output logic                  do_checkpoint_o,
    output logic                  do_recover_o,
    output logic                  delete_checkpoint_o,

    output logic                  commit_flush_o,
    output logic [RETIRE_W-1:0]   commit_update_o,
    output logic                  enable_commit_o,

    output logic                  flush_gl_o,
    output logic [GL_INDEX_W-1:0] flush_gl_index_o
);

    cu_event_if events ();

    cu_event_state #(
        .RETIRE_W (RETIRE_W)
    ) u_event_state (
        .clk_i, .rstn_i,
        .id_valid_i, .id_is_branch_i, .id_predicted_branch_i, .id_valid_jal_i,
        .id_csr_fence_i, .wb_valid_i, .branch_pred_ok_i,
        .commit_valid_i, .commit_xcpt_i, .commit_ecall_i, .commit_csr_fence_i,
        .commit_fence_i, .commit_fencei_i, .commit_retire_i, .commit_regfile_we_i,
        .commit_stall_i, .csr_eret_i, .csr_exception_i,
        .events (events.src),
        .invalidate_icache_o, .invalidate_buffer_o, .commit_flush_o,
        .commit_update_o, .enable_commit_o
    );

    cu_frontend_ctrl u_frontend_ctrl (
        .events (events.dst),
        .miss_icache_i, .ready_icache_i, .csr_stall_i, .ir_full_iq_i,
        .next_pc_sel_o, .fetch_sel_o, .flush_if_o, .flush_id_o,
        .stall_if_1_o, .stall_if_2_o, .stall_id_o
    );

    cu_backend_ctrl #(
        .GL_INDEX_W (GL_INDEX_W)
    ) u_backend_ctrl (
        .events (events.dst),
        .csr_stall_i, .exe_stall_i, .rr_gl_full_i, .ir_empty_free_list_i,
        .ir_out_of_chkp_i, .ir_valid_i, .ir_is_branch_i,
        .wb_valid_i, .wb_write_enable_i, .wb_checkpoint_done_i, .branch_pred_ok_i,
        .wb_gl_index_i, .commit_valid_i, .commit_xcpt_i, .csr_exception_i,
        .commit_write_enable_i,
        .flush_ir_o, .flush_rr_o, .flush_exe_o, .kill_exe_o,
        .stall_iq_o, .stall_ir_o, .stall_rr_o, .stall_exe_o,
        .do_checkpoint_o, .do_recover_o, .delete_checkpoint_o,
        .flush_gl_o, .flush_gl_index_o, .rf_write_enable_o
    );

endmodule

//--- control_unit_sva.sv
module control_unit_sva (
    input logic               clk_i,
    input logic               rstn_i,
    input logic               flush_if_o,
    input logic               flush_id_o,
    input logic               flush_ir_o,
    input logic               flush_rr_o,
    input logic               flush_exe_o,
    input logic               kill_exe_o,
    input cu_pkg::fetch_sel_e fetch_sel_o,
    input logic               stall_rr_o,
    input logic               stall_exe_o
);

    timeunit 1ns;
    timeprecision 100ps;

    import cu_pkg::*;

    // exe is either flushed by a trap or killed by a mispredict
    exe_flush_xor_kill : assert property (
        @(posedge clk_i) disable iff (!rstn_i) !(flush_exe_o && kill_exe_o)
    ) else $error("flush_exe_o and kill_exe_o are high in the same cycle");

    // trap redirect lasts a single cycle
    trap_select_single : assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        (fetch_sel_o == FETCH_SEL_CSR) |=> (fetch_sel_o != FETCH_SEL_CSR)
    ) else $error("fetch_sel_o stayed at FETCH_SEL_CSR for two cycles");

    exe_stall_holds_rr : assert property (
        @(posedge clk_i) disable iff (!rstn_i) stall_exe_o |-> stall_rr_o
    ) else $error("stall_exe_o is high without stall_rr_o");

    no_flush_after_reset : assert property (
        @(posedge clk_i) $rose(rstn_i) |->
            !(flush_if_o || flush_id_o || flush_ir_o || flush_rr_o || flush_exe_o)
    ) else $error("a flush output is high in the first cycle after reset");

endmodule

bind control_unit control_unit_sva u_control_unit_sva (
    .clk_i, .rstn_i,
    .flush_if_o, .flush_id_o, .flush_ir_o, .flush_rr_o, .flush_exe_o, .kill_exe_o,
    .fetch_sel_o, .stall_rr_o, .stall_exe_o
);

//--- tb_control_unit.sv
module tb_control_unit;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int GL_INDEX_W  = 5;
    localparam int RETIRE_W    = 2;
    localparam int IN_W        = 44;
    localparam int OUT_W       = 40;
    localparam int MAX_VECTORS = 64;
    localparam int NUM_FIELDS  = 26;

    logic            clk_i = 1'b0;
    logic            rstn_i;
    logic [IN_W-1:0] stim;
    wire [OUT_W-1:0] got;

    // id, input word and expected word for each vector, in that order
    logic [IN_W-1:0] vec_mem [0:3*MAX_VECTORS-1];

    int         num_vectors = 0;
    int         test_errors = 0;
    int         test_cycles = 0;
    int         tests_passed = 0;
    int         tests_failed = 0;
    logic [7:0] test_id;
    logic [7:0] last_id;

    string field_name [NUM_FIELDS] = '{
        "next_pc_sel_o", "fetch_sel_o", "flush_if_o", "flush_id_o", "flush_ir_o",
        "flush_rr_o", "flush_exe_o", "kill_exe_o", "stall_if_1_o", "stall_if_2_o",
        "stall_id_o", "stall_iq_o", "stall_ir_o", "stall_rr_o", "stall_exe_o",
        "invalidate_icache_o", "invalidate_buffer_o", "rf_write_enable_o",
        "do_checkpoint_o", "do_recover_o", "delete_checkpoint_o", "commit_flush_o",
        "enable_commit_o", "commit_update_o", "flush_gl_o", "flush_gl_index_o"
    };
    int field_lsb [NUM_FIELDS] = '{
        38, 36, 35, 34, 33, 32, 31, 30, 27, 26, 25, 24, 23, 22, 21,
        19, 18, 17, 15, 14, 13, 11, 10, 8, 7, 0
    };
    int field_width [NUM_FIELDS] = '{
        2, 2, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1,
        1, 1, 1, 1, 1, 1, 1, 1, 2, 1, 5
    };

    always #5 clk_i = ~clk_i;

    // unused nibble bits of the response word
    assign got[29:28] = 2'b00;
    assign got[20]    = 1'b0;
    assign got[16]    = 1'b0;
    assign got[12]    = 1'b0;
    assign got[6:5]   = 2'b00;

    control_unit #(
        .GL_INDEX_W (GL_INDEX_W),
        .RETIRE_W   (RETIRE_W)
    ) u_control_unit (
        .clk_i (clk_i), .rstn_i (rstn_i),
        .miss_icache_i (stim[43]), .ready_icache_i (stim[42]),
        .id_valid_i (stim[41]), .id_is_branch_i (stim[40]),
        .id_predicted_branch_i (stim[39]), .id_valid_jal_i (stim[38]),
        .id_csr_fence_i (stim[37]),
        .ir_valid_i (stim[35]), .ir_is_branch_i (stim[34]),
        .ir_out_of_chkp_i (stim[33]), .ir_full_iq_i (stim[32]),
        .ir_empty_free_list_i (stim[31]), .rr_gl_full_i (stim[30]), .exe_stall_i (stim[29]),
        .wb_valid_i (stim[27]), .wb_write_enable_i (stim[26]),
        .wb_checkpoint_done_i (stim[25]), .branch_pred_ok_i (stim[24]),
        .wb_gl_index_i (stim[20:16]),
        .commit_valid_i (stim[15]), .commit_xcpt_i (stim[14]),
        .commit_ecall_i (stim[13]), .commit_csr_fence_i (stim[12]),
        .commit_fence_i (stim[11]), .commit_fencei_i (stim[10]),
        .commit_write_enable_i (stim[9]), .commit_stall_i (stim[8]),
        .commit_retire_i (stim[7:6]), .commit_regfile_we_i (stim[5:4]),
        .csr_eret_i (stim[3]), .csr_exception_i (stim[2]), .csr_stall_i (stim[1]),
        .next_pc_sel_o (got[39:38]), .fetch_sel_o (got[37:36]),
        .flush_if_o (got[35]), .flush_id_o (got[34]), .flush_ir_o (got[33]),
        .flush_rr_o (got[32]), .flush_exe_o (got[31]), .kill_exe_o (got[30]),
        .stall_if_1_o (got[27]), .stall_if_2_o (got[26]), .stall_id_o (got[25]),
        .stall_iq_o (got[24]), .stall_ir_o (got[23]), .stall_rr_o (got[22]),
        .stall_exe_o (got[21]),
        .invalidate_icache_o (got[19]), .invalidate_buffer_o (got[18]),
        .rf_write_enable_o (got[17]),
        .do_checkpoint_o (got[15]), .do_recover_o (got[14]), .delete_checkpoint_o (got[13]),
        .commit_flush_o (got[11]), .enable_commit_o (got[10]), .commit_update_o (got[9:8]),
        .flush_gl_o (got[7]), .flush_gl_index_o (got[4:0])
    );

    // compare the response word one output at a time
    task automatic check_outputs(input logic [OUT_W-1:0] exp_word);
        logic [OUT_W-1:0] mask;
        logic [OUT_W-1:0] got_field;
        logic [OUT_W-1:0] exp_field;
        for (int f = 0; f < NUM_FIELDS; f++) begin
            mask      = (OUT_W'(1) << field_width[f]) - OUT_W'(1);
            got_field = (got >> field_lsb[f]) & mask;
            exp_field = (exp_word >> field_lsb[f]) & mask;
            assert (got_field === exp_field) else begin
                $display("FAIL %0t: %s is 0x%0h, expected 0x%0h",
                         $time, field_name[f], got_field, exp_field);
                test_errors++;
            end
        end
    endtask

    task automatic close_test(input logic [7:0] id);
        if (test_errors == 0) begin
            $display("test %02h: passed in %0d cycles", id, test_cycles);
            tests_passed++;
        end else begin
            $display("test %02h: %0d mismatches in %0d cycles", id, test_errors, test_cycles);
            tests_failed++;
        end
        test_errors = 0;
        test_cycles = 0;
    endtask

    initial begin
        stim   = '0;
        rstn_i = 1'b0;
        // unloaded slots keep the top bit set, test ids never reach it
        for (int i = 0; i < 3 * MAX_VECTORS; i++) begin
            vec_mem[i] = {1'b1, (IN_W-1)'(i)};
        end
        $readmemh("control_unit_vectors.txt", vec_mem);
        while (num_vectors < MAX_VECTORS && !vec_mem[3 * num_vectors][IN_W-1]) begin
            num_vectors++;
        end

        repeat (2) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;

        // one vector per cycle, checked just before the next edge
        for (int v = 0; v < num_vectors; v++) begin
            test_id = vec_mem[3 * v][7:0];
            if (v > 0 && test_id != last_id) begin
                close_test(last_id);
            end
            last_id = test_id;
            stim = vec_mem[3 * v + 1];
            test_cycles++;
            #8;
            check_outputs(vec_mem[3 * v + 2][OUT_W-1:0]);
            @(posedge clk_i);
            #1;
        end
        if (num_vectors > 0) begin
            close_test(last_id);
        end else begin
            $display("no vectors could be read from control_unit_vectors.txt");
        end

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && num_vectors > 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // run length follows the vector count plus a margin for reset
    initial begin
        wait (num_vectors > 0);
        #((num_vectors + 10) * 10);
        $display("run timed out before all %0d vectors were applied", num_vectors);
        $display("TEST FAIL");
        $finish;
    end

endmodule

//--- vlog.f
cu_pkg.sv
cu_event_if.sv
cu_event_state.sv
cu_frontend_ctrl.sv
cu_backend_ctrl.sv
control_unit.sv
control_unit_sva.sv
tb_control_unit.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the control unit testbench with Verilator, run it and check the log
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f vlog.f --top-module tb_control_unit -o sim_control_unit

./obj_dir/sim_control_unit | tee sim.log

if grep -q "TEST FAIL" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi

if ! grep -q "TEST PASS" sim.log; then
    echo "simulation ended without a pass message, see sim.log"
    exit 1
fi

//--- control_unit_vectors.txt
// columns: test id, input word (11 hex digits), expected output word (10 hex digits)
// words pack one nibble per signal group, msb first, as mapped in tb_control_unit.sv
01 40000000000 0000000400
01 40000000000 0000000400
02 4000A0B0000 5F4000448B
02 4000F050000 0000022400
02 400081F0000 5F4000049F
03 4000000C2F0 0000000000
03 4000000C2F0 6F80040F00
03 4000000C2F0 0000000000
03 40000000000 6F80000C00
04 62000000000 8800000400
04 40000000000 8800000400
04 40000009000 8808040400
04 40000000000 7C00000400
04 40000000000 0000000400
05 800E0000002 800FE00400
05 40040000000 0101C00400
05 401A0000000 800FC00400
05 80200000000 800D000400
05 00000000000 8008000400
06 40C00000000 0000008400
06 40C20000000 0001C00400
06 40000008600 00000E0400
06 40000008B70 8800020100
06 64000000000 4800000400
